// ==== rtl/msx_pkg.sv ====
package msx_pkg;

   // One CPU bus request, held stable by the master until it completes
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  dout;
      logic        rd;
      logic        wr;
      logic        mreq;
      logic        iorq;
      logic        m1;
   } cpu_req_t;

   // Segment number for each 16 KB page of the mapper
   typedef struct packed {
      logic [7:0] seg3;
      logic [7:0] seg2;
      logic [7:0] seg1;
      logic [7:0] seg0;
   } mapper_regs_t;

   // I/O port addresses
   localparam logic [7:0] PORT_SLOT   = 8'hA8;
   localparam logic [7:0] PORT_PPI_C  = 8'hAA;
   localparam logic [7:0] PORT_MAPPER = 8'hFC;

   // 64 segments, 1 MB of mapped RAM
   localparam int SEG_BITS = 6;

   localparam logic [1:0] SLOT_ROM = 2'd0;
   localparam logic [1:0] SLOT_RAM = 2'd3;

   localparam int RAM_ADDR_W = 27;

   // Mapper state after reset, pages 0..3 on segments 3..0
   localparam mapper_regs_t MAPPER_RESET = '{seg3: 8'd0, seg2: 8'd1, seg1: 8'd2, seg0: 8'd3};

   // Mixer weights
   localparam logic signed [16:0] CLICK_LEVEL = 17'sd512;
   localparam logic signed [16:0] TAPE_LEVEL  = 17'sd256;

endpackage

// ==== rtl/m1_wait_gen.sv ====
`timescale 1ns/1ps

module m1_wait_gen import msx_pkg::*; (
   input  logic     clock_bus,
   input  logic     rst_n,
   input  cpu_req_t cpu,
   output logic     wait_n
);

   logic req_active;
   logic m1_read;
   logic waited;

   // Exactly one direction and exactly one space
   assign req_active = (cpu.rd ^ cpu.wr) & (cpu.mreq ^ cpu.iorq);
   assign m1_read    = req_active & cpu.m1 & cpu.rd;

   // First cycle of an opcode fetch is stretched by one
   assign wait_n = ~(m1_read & ~waited);

   // Set after the wait cycle, cleared on the completing edge
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         waited <= 1'b0;
      end else begin
         waited <= m1_read & ~waited;
      end
   end

   // A single wait state, never a stall
   wait_single_cycle : assert property (
      @(posedge clock_bus) disable iff (!rst_n)
      !wait_n |=> wait_n
   ) else $error("wait_n held low for more than one cycle");

endmodule

// ==== rtl/io_devices.sv ====
`timescale 1ns/1ps

module io_devices import msx_pkg::*; (
   input  logic         clock_bus,
   input  logic         rst_n,
   input  cpu_req_t     cpu,
   input  logic         wait_n,
   output logic [7:0]   io_data,
   output logic         io_oe,
   output logic [7:0]   slot_config,
   output mapper_regs_t mapper,
   output logic         keyclick,
   output logic         tape_motor_on
);

   logic       io_req;
   logic       io_wr_done;
   logic [7:0] port;
   logic       sel_slot;
   logic       sel_ppi_c;
   logic       sel_mapper;
   logic [7:0] ppi_c;
   logic [7:0] seg_sel;

   assign io_req     = cpu.iorq & ~cpu.mreq & (cpu.rd ^ cpu.wr);
   assign io_wr_done = io_req & cpu.wr & wait_n;

   // Z80 I/O decodes only the low address byte
   assign port       = cpu.addr[7:0];
   assign sel_slot   = (port == PORT_SLOT);
   assign sel_ppi_c  = (port == PORT_PPI_C);
   assign sel_mapper = (port[7:2] == PORT_MAPPER[7:2]);

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         slot_config <= 8'h00;
         ppi_c       <= 8'h00;
         mapper      <= MAPPER_RESET;
      end else if (io_wr_done) begin
         if (sel_slot) begin
            slot_config <= cpu.dout;
         end
         if (sel_ppi_c) begin
            ppi_c <= cpu.dout;
         end
         if (sel_mapper) begin
            case (port[1:0])
               2'd0:    mapper.seg0 <= cpu.dout;
               2'd1:    mapper.seg1 <= cpu.dout;
               2'd2:    mapper.seg2 <= cpu.dout;
               default: mapper.seg3 <= cpu.dout;
            endcase
         end
      end
   end

   always_comb begin
      case (port[1:0])
         2'd0:    seg_sel = mapper.seg0;
         2'd1:    seg_sel = mapper.seg1;
         2'd2:    seg_sel = mapper.seg2;
         default: seg_sel = mapper.seg3;
      endcase
   end

   // Read-back; unused segment bits read as ones
   always_comb begin
      io_oe   = 1'b0;
      io_data = 8'hFF;
      if (io_req && cpu.rd) begin
         if (sel_slot) begin
            io_oe   = 1'b1;
            io_data = slot_config;
         end else if (sel_ppi_c) begin
            io_oe   = 1'b1;
            io_data = ppi_c;
         end else if (sel_mapper) begin
            io_oe   = 1'b1;
            io_data = {{(8 - SEG_BITS){1'b1}}, seg_sel[SEG_BITS-1:0]};
         end
      end
   end

   assign keyclick      = ppi_c[7];
   assign tape_motor_on = ppi_c[4];

   // CPU side never drives both strobes
   rd_wr_exclusive : assert property (
      @(posedge clock_bus) disable iff (!rst_n)
      !(cpu.rd && cpu.wr)
   ) else $error("rd and wr both high");

endmodule

// ==== rtl/slot_decoder.sv ====
`timescale 1ns/1ps

module slot_decoder import msx_pkg::*; (
   input  cpu_req_t                cpu,
   input  logic [7:0]              slot_config,
   input  mapper_regs_t            mapper,
   output logic [RAM_ADDR_W-1:0]   ram_addr,
   output logic [7:0]              ram_din,
   output logic                    ram_rnw,
   output logic                    sdram_ce,
   output logic                    bram_ce,
   output logic                    mem_oe
);

   logic       mem_req;
   logic [1:0] page;
   logic [1:0] active_slot;
   logic [7:0] segment;
   logic       rom_hit;
   logic       ram_hit;

   assign mem_req = cpu.mreq & ~cpu.iorq & (cpu.rd ^ cpu.wr);
   assign page    = cpu.addr[15:14];

   // Two slot bits per page in the primary slot register
   always_comb begin
      case (page)
         2'd0:    active_slot = slot_config[1:0];
         2'd1:    active_slot = slot_config[3:2];
         2'd2:    active_slot = slot_config[5:4];
         default: active_slot = slot_config[7:6];
      endcase
   end

   always_comb begin
      case (page)
         2'd0:    segment = mapper.seg0;
         2'd1:    segment = mapper.seg1;
         2'd2:    segment = mapper.seg2;
         default: segment = mapper.seg3;
      endcase
   end

   // ROM only covers the lower 32 KB of slot 0
   assign rom_hit = mem_req & (active_slot == SLOT_ROM) & ~page[1];
   assign ram_hit = mem_req & (active_slot == SLOT_RAM);

   assign bram_ce  = rom_hit & cpu.rd;
   assign sdram_ce = ram_hit;
   assign mem_oe   = (rom_hit | ram_hit) & cpu.rd;

   // Segment * 16 KB plus the page offset
   assign ram_addr = ram_hit ?
      {{(RAM_ADDR_W - SEG_BITS - 14){1'b0}}, segment[SEG_BITS-1:0], cpu.addr[13:0]} :
      {{(RAM_ADDR_W - 15){1'b0}}, cpu.addr[14:0]};

   assign ram_din = cpu.dout;
   assign ram_rnw = cpu.rd;

   always_comb begin
      ce_exclusive : assert (!(sdram_ce && bram_ce))
         else $error("sdram_ce and bram_ce both high");
   end

endmodule

// ==== rtl/audio_mix.sv ====
`timescale 1ns/1ps

module audio_mix import msx_pkg::*; (
   input  logic               clock_bus,
   input  logic               rst_n,
   input  logic signed [15:0] psg_sound,
   input  logic               keyclick,
   input  logic               tape_in,
   input  logic               tape_motor_on,
   output logic signed [15:0] audio
);

   logic signed [16:0] click_term;
   logic signed [16:0] tape_term;
   logic signed [16:0] mix;
   logic signed [15:0] mix_sat;

   assign click_term = keyclick ? CLICK_LEVEL : 17'sd0;
   // Tape is only heard while the motor is stopped
   assign tape_term  = (tape_in && !tape_motor_on) ? TAPE_LEVEL : 17'sd0;

   assign mix = {psg_sound[15], psg_sound} + click_term + tape_term;

   // Top two bits differ on overflow of the 16-bit range
   always_comb begin
      case (mix[16:15])
         2'b01:   mix_sat = 16'sh7FFF;
         2'b10:   mix_sat = 16'sh8000;
         default: mix_sat = mix[15:0];
      endcase
   end

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         audio <= 16'sd0;
      end else begin
         audio <= mix_sat;
      end
   end

endmodule

// ==== rtl/msx_core.sv ====
`timescale 1ns/1ps

module msx_core import msx_pkg::*; (
   input  logic                  clock_bus,
   input  logic                  rst_n,
   input  cpu_req_t              cpu,
   output logic                  wait_n,
   output logic [7:0]            cpu_din,
   output logic [RAM_ADDR_W-1:0] ram_addr,
   output logic [7:0]            ram_din,
   output logic                  ram_rnw,
   output logic                  sdram_ce,
   output logic                  bram_ce,
   input  logic [7:0]            ram_dout,
   input  logic signed [15:0]    psg_sound,
   input  logic                  tape_in,
   output logic                  tape_motor_on,
   output logic signed [15:0]    audio
);

   logic [7:0]   io_data;
   logic         io_oe;
   logic [7:0]   slot_config;
   mapper_regs_t mapper;
   logic         keyclick;
   logic         mem_oe;

   m1_wait_gen u_m1_wait_gen (
      .clock_bus (clock_bus),
      .rst_n     (rst_n),
      .cpu       (cpu),
      .wait_n    (wait_n)
   );

   io_devices u_io_devices (
      .clock_bus     (clock_bus),
      .rst_n         (rst_n),
      .cpu           (cpu),
      .wait_n        (wait_n),
      .io_data       (io_data),
      .io_oe         (io_oe),
      .slot_config   (slot_config),
      .mapper        (mapper),
      .keyclick      (keyclick),
      .tape_motor_on (tape_motor_on)
   );

   slot_decoder u_slot_decoder (
      .cpu         (cpu),
      .slot_config (slot_config),
      .mapper      (mapper),
      .ram_addr    (ram_addr),
      .ram_din     (ram_din),
      .ram_rnw     (ram_rnw),
      .sdram_ce    (sdram_ce),
      .bram_ce     (bram_ce),
      .mem_oe      (mem_oe)
   );

   audio_mix u_audio_mix (
      .clock_bus     (clock_bus),
      .rst_n         (rst_n),
      .psg_sound     (psg_sound),
      .keyclick      (keyclick),
      .tape_in       (tape_in),
      .tape_motor_on (tape_motor_on),
      .audio         (audio)
   );

   // I/O wins over memory, empty bus reads FFh
   assign cpu_din = !cpu.rd ? 8'hFF    :
                    io_oe   ? io_data  :
                    mem_oe  ? ram_dout :
                              8'hFF;

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
   output logic clock_bus,
   output logic rst_n
);

   localparam int HALF_PERIOD  = 5;
   localparam int RESET_CYCLES = 8;

   initial begin
      clock_bus = 1'b0;
      forever #HALF_PERIOD clock_bus = ~clock_bus;
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clock_bus);
      @(negedge clock_bus);
      rst_n = 1'b1;
   end

endmodule

// ==== bench/tb_msx_core.sv ====
`timescale 1ns/1ps

module tb_msx_core import msx_pkg::*; ();

   logic               clock_bus;
   logic               rst_n;
   cpu_req_t           cpu;
   logic               wait_n;
   logic [7:0]         cpu_din;
   logic [26:0]        ram_addr;
   logic [7:0]         ram_din;
   logic               ram_rnw;
   logic               sdram_ce;
   logic               bram_ce;
   logic [7:0]         ram_dout;
   logic signed [15:0] psg_sound;
   logic               tape_in;
   logic               tape_motor_on;
   logic signed [15:0] audio;

   logic [7:0] rom_mem [0:32767];
   logic [7:0] ram_mem [0:1048575];
   logic [7:0] model_ram [0:1048575];
   logic [7:0] ref_slot;
   logic [7:0] ref_ppi;
   logic [7:0] ref_seg [4];
   integer     seed = 32'ha790;
   int         checks = 0;
   int         errors = 0;
   logic       timed_out = 1'b0;

   clock_gen u_clock_gen (.clock_bus(clock_bus), .rst_n(rst_n));

   msx_core uut (
      .clock_bus (clock_bus), .rst_n (rst_n), .cpu (cpu), .wait_n (wait_n),
      .cpu_din (cpu_din), .ram_addr (ram_addr), .ram_din (ram_din),
      .ram_rnw (ram_rnw), .sdram_ce (sdram_ce), .bram_ce (bram_ce),
      .ram_dout (ram_dout), .psg_sound (psg_sound), .tape_in (tape_in),
      .tape_motor_on (tape_motor_on), .audio (audio)
   );

   function automatic logic [7:0] rom_byte(input logic [14:0] a);
      return a[7:0] ^ {1'b1, a[14:8]};
   endfunction

   function automatic logic [7:0] ram_byte(input logic [19:0] a);
      return a[7:0] ^ a[15:8] ^ {a[19:16], 4'hC};
   endfunction

   function automatic logic [15:0] rnd16();
      logic [31:0] r;
      r = $random(seed);
      return r[15:0];
   endfunction

   // Memory model, ROM on bram_ce and mapped RAM on sdram_ce
   assign ram_dout = bram_ce ? rom_mem[ram_addr[14:0]] :
                     (sdram_ce && ram_rnw) ? ram_mem[ram_addr[19:0]] : 8'hFF;

   initial begin
      for (int i = 0; i < 32768; i++) rom_mem[i[14:0]] = rom_byte(i[14:0]);
      for (int i = 0; i < 1048576; i++) ram_mem[i[19:0]] = ram_byte(i[19:0]);
      forever begin
         @(posedge clock_bus);
         if (sdram_ce && !ram_rnw && wait_n) ram_mem[ram_addr[19:0]] = ram_din;
      end
   end

   function automatic logic [7:0] io_expect(input logic [7:0] port);
      if (port == 8'hA8) return ref_slot;
      if (port == 8'hAA) return ref_ppi;
      // Upper segment bits read as ones
      if (port[7:2] == 6'h3F) return {2'b11, ref_seg[port[1:0]][5:0]};
      return 8'hFF;
   endfunction

   function automatic logic signed [15:0] mix_expect(input logic signed [15:0] psg,
                                                      input logic click, input logic tape,
                                                      input logic motor);
      int sum;
      sum = int'(psg);
      if (click) sum = sum + 512;
      if (tape && !motor) sum = sum + 256;
      if (sum > 32767) sum = 32767;
      else if (sum < -32768) sum = -32768;
      return sum[15:0];
   endfunction

   task automatic expect_byte(input string what, input logic [7:0] got,
                              input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // One request, held until the edge where wait_n is high
   task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] wdata,
                            input logic rd, input logic mreq, input logic m1,
                            output logic [7:0] rdata, output logic bram_s,
                            output logic sdram_s, output logic [26:0] addr_s);
      cpu_req_t req;
      int       cycles;
      int       waits;
      logic     done;
      req = '{addr: addr, dout: wdata, rd: rd, wr: !rd, mreq: mreq, iorq: !mreq, m1: m1};
      cycles = 0;
      waits = 0;
      done = 1'b0;
      rdata = 8'hFF;
      bram_s = 1'b0;
      sdram_s = 1'b0;
      addr_s = '0;
      @(posedge clock_bus);
      cpu <= req;
      while (!done && !timed_out) begin
         @(negedge clock_bus);
         cycles++;
         if (wait_n) begin
            rdata   = cpu_din;
            bram_s  = bram_ce;
            sdram_s = sdram_ce;
            addr_s  = ram_addr;
            done    = 1'b1;
         end else begin
            waits++;
         end
         if (!done && cycles >= 10) begin
            $display("Timeout: wait_n stayed low for %0d cycles at %0t", cycles, $time);
            errors++;
            timed_out = 1'b1;
         end
      end
      @(posedge clock_bus);
      cpu <= '0;
      // Opcode fetch costs one extra cycle
      checks++;
      if (cycles != ((m1 && rd) ? 2 : 1) || waits != cycles - 1) begin
         errors++;
         $display("Mismatch at %0t: access to %h took %0d cycles, %0d waits",
                  $time, addr, cycles, waits);
      end
      // I/O cycles leave both memory strobes low
      if (!mreq) begin
         checks++;
         if (bram_s || sdram_s) begin
            errors++;
            $display("Mismatch at %0t: memory strobe high on I/O access to %h",
                     $time, addr);
         end
      end
   endtask

   task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
      logic [7:0]  rdata;
      logic        bram_s;
      logic        sdram_s;
      logic [26:0] addr_s;
      bus_cycle(addr, data, 1'b0, 1'b0, 1'b0, rdata, bram_s, sdram_s, addr_s);
      if (addr[7:0] == 8'hA8) ref_slot = data;
      else if (addr[7:0] == 8'hAA) ref_ppi = data;
      else if (addr[7:2] == 6'h3F) ref_seg[addr[1:0]] = data;
   endtask

   task automatic io_read(input logic [15:0] addr);
      logic [7:0]  rdata;
      logic        bram_s;
      logic        sdram_s;
      logic [26:0] addr_s;
      bus_cycle(addr, 8'h00, 1'b1, 1'b0, 1'b0, rdata, bram_s, sdram_s, addr_s);
      expect_byte("I/O read", rdata, io_expect(addr[7:0]));
   endtask

   task automatic mem_access(input logic [15:0] addr, input logic [7:0] wdata,
                             input logic rd, input logic m1);
      logic [1:0]  page;
      logic [1:0]  slot;
      logic        is_rom;
      logic        is_ram;
      logic [19:0] ram_index;
      logic [7:0]  exp_data;
      logic [7:0]  rdata;
      logic        bram_s;
      logic        sdram_s;
      logic [26:0] addr_s;
      page      = addr[15:14];
      slot      = ref_slot[{page, 1'b0} +: 2];
      is_rom    = (slot == 2'd0) && !page[1];
      is_ram    = (slot == 2'd3);
      ram_index = {ref_seg[page][5:0], addr[13:0]};
      exp_data  = 8'hFF;
      if (is_rom) exp_data = rom_byte(addr[14:0]);
      if (is_ram) exp_data = model_ram[ram_index];
      bus_cycle(addr, wdata, rd, 1'b1, m1, rdata, bram_s, sdram_s, addr_s);
      checks++;
      if (bram_s !== (is_rom && rd) || sdram_s !== is_ram) begin
         errors++;
         $display("Mismatch at %0t: strobes for %h bram_ce %b sdram_ce %b",
                  $time, addr, bram_s, sdram_s);
      end
      checks++;
      if (is_ram && addr_s !== {7'd0, ram_index}) begin
         errors++;
         $display("Mismatch at %0t: ram_addr %h expected %h", $time, addr_s, ram_index);
      end
      if (rd) expect_byte("memory read", rdata, exp_data);
      else if (is_ram) model_ram[ram_index] = wdata;
   endtask

   task automatic audio_step(input logic signed [15:0] psg, input logic tape);
      logic signed [15:0] exp_audio;
      exp_audio = mix_expect(psg, ref_ppi[7], tape, ref_ppi[4]);
      @(posedge clock_bus);
      psg_sound <= psg;
      tape_in   <= tape;
      // Registered mixer, one clock of latency
      @(posedge clock_bus);
      @(negedge clock_bus);
      checks++;
      if (audio !== exp_audio || tape_motor_on !== ref_ppi[4]) begin
         errors++;
         $display("Mismatch at %0t: audio %0d expected %0d, motor %b",
                  $time, audio, exp_audio, tape_motor_on);
      end
   endtask

   initial begin
      wait (timed_out);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Test FAILED");
      $finish;
   end

   initial begin
      logic [15:0]        r;
      logic [15:0]        r2;
      logic signed [15:0] psg;
      int                 n;
      cpu       <= '0;
      psg_sound <= '0;
      tape_in   <= 1'b0;
      ref_slot = 8'h00;
      ref_ppi  = 8'h00;
      ref_seg  = '{8'd3, 8'd2, 8'd1, 8'd0};
      for (int i = 0; i < 1048576; i++) model_ram[i[19:0]] = ram_byte(i[19:0]);
      n = 0;
      while (rst_n !== 1'b1 && n < 100) begin
         @(posedge clock_bus);
         n++;
      end
      if (rst_n !== 1'b1) begin
         $display("Timeout: reset was never released");
         errors++;
         timed_out = 1'b1;
      end
      @(negedge clock_bus);
      checks++;
      if (audio !== 16'sd0) begin
         errors++;
         $display("Mismatch at %0t: audio %0d after reset", $time, audio);
      end
      // Register state right after reset
      io_read(16'h00A8);
      io_read(16'h00AA);
      for (int p = 0; p < 4; p++) io_read({8'h00, 6'h3F, p[1:0]});
      // I/O ports, random high address byte
      for (int i = 0; i < 300; i++) begin
         r  = rnd16();
         r2 = rnd16();
         if (r[2]) n = {6'h3F, r[1:0]};
         else if (r[1]) n = 8'hAA;
         else if (r[0]) n = 8'hA8;
         else n = r[15:8];
         if (r[3]) io_write({r2[15:8], n[7:0]}, r2[7:0]);
         else io_read({r2[15:8], n[7:0]});
      end
      // Memory under changing slot and mapper settings
      for (int i = 0; i < 2000; i++) begin
         r  = rnd16();
         r2 = rnd16();
         if (r[4:0] == 5'd0) io_write({r2[15:8], 8'hA8}, r2[7:0]);
         else if (r[4:0] == 5'd1) io_write({r2[15:8], 6'h3F, r[6:5]}, r2[7:0] & 8'hC3);
         else mem_access({r2[15:14], 8'h00, r2[5:0]}, r[15:8], r[7], r[7] & r[8]);
      end
      // Mixer, including both ends of the range
      for (int i = 0; i < 300; i++) begin
         r  = rnd16();
         r2 = rnd16();
         if (r[2:0] == 3'd0) io_write(16'h00AA, r2[7:0]);
         case (r[4:3])
            2'd0:    psg = {8'h7F, r2[15:8]};
            2'd1:    psg = {8'h80, r2[15:8]};
            default: psg = r2;
         endcase
         audio_step(psg, r[5]);
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
rtl/msx_pkg.sv
rtl/m1_wait_gen.sv
rtl/io_devices.sv
rtl/slot_decoder.sv
rtl/audio_mix.sv
rtl/msx_core.sv
bench/clock_gen.sv
bench/tb_msx_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   --top-module tb_msx_core \
   -f compile.f \
   -o Vtb_msx_core

./obj_dir/Vtb_msx_core | tee sim.log

if grep -q "Test FAILED" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
echo "Simulation finished without failure"
